// File: logic/wb2sdrc_consts.svh
// ------------------------------------------------
// widths and queue depths of the wishbone to sdram
// controller bridge, included by the package and rtl
// ------------------------------------------------
`ifndef WB2SDRC_CONSTS_SVH
`define WB2SDRC_CONSTS_SVH

// data word width, bytes follow from it
`define WB2SDRC_DW 32

// application word address width
`define WB2SDRC_AW 26

// command queue, one entry per request
`define WB2SDRC_CMD_DEPTH 4

// write data plus byte mask queue
`define WB2SDRC_WDATA_DEPTH 8

// read return queue
`define WB2SDRC_RDATA_DEPTH 4

`endif

// File: logic/wb2sdrc_pkg.sv
// ------------------------------------------------
// named vector types shared by the bridge rtl and the
// controller stub, import where a type is needed
// ------------------------------------------------
`include "wb2sdrc_consts.svh"

package wb2sdrc_pkg;

	// request address, one word per request
	typedef logic [`WB2SDRC_AW-1:0] addr_t;

	// one data word, same width both directions
	typedef logic [`WB2SDRC_DW-1:0] data_t;

	// byte lanes
	// active high as wb_sel_i, active low toward the controller
	typedef logic [`WB2SDRC_DW/8-1:0] sel_t;

endpackage

// File: logic/sync_fifo.sv
// ------------------------------------------------
// show-ahead synchronous fifo, head word valid while
// not empty, pop and push may happen in one cycle
// ------------------------------------------------
module sync_fifo #(
	parameter int unsigned width = 8,
	parameter int unsigned depth = 4
) (
	input  logic             sdram_clk,
	input  logic             wb_clk_i,
	input  logic             push_i,
	input  logic             pop_i,
	input  logic [width-1:0] wdata_i,
	output logic [width-1:0] rdata_o,
	output logic             full_o,
	output logic             empty_o
);

	localparam int unsigned aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int unsigned cw = $clog2(depth + 1);

	// storage, no reset needed on payload
	logic [width-1:0] mem [depth];

	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;

	logic do_push;
	logic do_pop;

	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	// flags straight off the registered count
	assign full_o  = (count == cw'(depth));
	assign empty_o = (count == '0);

	// head word shown combinationally
	assign rdata_o = mem[rd_ptr];

	always_ff @(posedge sdram_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wdata_i;
		end
	end

	// --------------------------------------------------
	// pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// wrap at depth, depth need not be a power of two
			if (do_push) begin
				wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

	// callers must respect the flags
	a_no_overflow: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		full_o |-> !push_i
	) else $error("fifo push while full");

	a_no_underflow: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		empty_o |-> !pop_i
	) else $error("fifo pop while empty");

endmodule

// File: logic/sdr_cmd_path.sv
// ------------------------------------------------
// write side of the bridge: command queue and write
// data queue, heads presented to the sdram controller
// ------------------------------------------------
`include "wb2sdrc_consts.svh"

module sdr_cmd_path (
	input  logic                sdram_clk,
	input  logic                wb_clk_i,
	input  logic                cmd_push_i,
	input  logic                wdata_push_i,
	input  logic                wb_we_i,
	input  wb2sdrc_pkg::addr_t  wb_addr_i,
	input  wb2sdrc_pkg::data_t  wb_dat_i,
	input  wb2sdrc_pkg::sel_t   wb_sel_i,
	input  logic                sdr_req_ack_i,
	input  logic                sdr_wr_next_i,
	output logic                sdr_req_o,
	output wb2sdrc_pkg::addr_t  sdr_req_addr_o,
	output logic                sdr_req_wr_n_o,
	output wb2sdrc_pkg::sel_t   sdr_wr_en_n_o,
	output wb2sdrc_pkg::data_t  sdr_wr_data_o,
	output logic                cmd_full_o,
	output logic                wdata_full_o
);

	import wb2sdrc_pkg::*;

	// command entry is {wr_n, addr}
	localparam int unsigned cmd_w = $bits(addr_t) + 1;
	// write entry is {mask_n, data}
	localparam int unsigned wd_w  = $bits(sel_t) + $bits(data_t);

	logic [cmd_w-1:0] cmd_in;
	logic [cmd_w-1:0] cmd_head;
	logic [wd_w-1:0]  wd_in;
	logic [wd_w-1:0]  wd_head;
	logic             cmd_empty;

	// controller mask is active low
	sel_t wr_mask_n;

	assign wr_mask_n = ~wb_sel_i;

	// --------------------------------------------------
	// command queue
	// --------------------------------------------------
	// wr_n low marks a write
	assign cmd_in = {!wb_we_i, wb_addr_i};

	sync_fifo #(
		.width (cmd_w),
		.depth (`WB2SDRC_CMD_DEPTH)
	) u_cmd_fifo (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.push_i    (cmd_push_i),
		.pop_i     (sdr_req_ack_i),
		.wdata_i   (cmd_in),
		.rdata_o   (cmd_head),
		.full_o    (cmd_full_o),
		.empty_o   (cmd_empty)
	);

	// request held while anything waits
	assign sdr_req_o = !cmd_empty;
	assign {sdr_req_wr_n_o, sdr_req_addr_o} = cmd_head;

	// --------------------------------------------------
	// write data queue
	// --------------------------------------------------
	assign wd_in = {wr_mask_n, wb_dat_i};

	// popped by wr_next, one entry per write command
	sync_fifo #(
		.width (wd_w),
		.depth (`WB2SDRC_WDATA_DEPTH)
	) u_wdata_fifo (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.push_i    (wdata_push_i),
		.pop_i     (sdr_wr_next_i),
		.wdata_i   (wd_in),
		.rdata_o   (wd_head),
		.full_o    (wdata_full_o),
		.empty_o   ()
	);

	assign {sdr_wr_en_n_o, sdr_wr_data_o} = wd_head;

endmodule

// File: logic/sdr_rd_return.sv
// ------------------------------------------------
// read return queue, filled by the controller read
// strobe and drained by the wishbone read acknowledge
// ------------------------------------------------
`include "wb2sdrc_consts.svh"

module sdr_rd_return (
	input  logic                sdram_clk,
	input  logic                wb_clk_i,
	input  logic                sdr_rd_valid_i,
	input  wb2sdrc_pkg::data_t  sdr_rd_data_i,
	input  logic                rdata_pop_i,
	output wb2sdrc_pkg::data_t  wb_dat_o,
	output logic                rdata_empty_o
);

	import wb2sdrc_pkg::*;

	localparam int unsigned rd_w = $bits(data_t);

	logic rdata_full;

	// head word drives wb_dat_o directly
	// readable the cycle after rd_valid
	sync_fifo #(
		.width (rd_w),
		.depth (`WB2SDRC_RDATA_DEPTH)
	) u_rdata_fifo (
		.sdram_clk (sdram_clk),
		.wb_clk_i  (wb_clk_i),
		.push_i    (sdr_rd_valid_i),
		.pop_i     (rdata_pop_i),
		.wdata_i   (sdr_rd_data_i),
		.rdata_o   (wb_dat_o),
		.full_o    (rdata_full),
		.empty_o   (rdata_empty_o)
	);

	// --------------------------------------------------
	// return data never meets a full queue
	// --------------------------------------------------
	// only one read is ever outstanding, so the previous word
	// has been acked and popped before the next one returns
	a_rd_room: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		sdr_rd_valid_i |-> (!rdata_full && rdata_empty_o)
	) else $error("read data returned with read queue occupied");

endmodule

// File: logic/wb_ack_ctrl.sv
// ------------------------------------------------
// wishbone acknowledge and queue strobes along with the
// pending read flag that limits reads to one at a time
// ------------------------------------------------
module wb_ack_ctrl (
	input  logic sdram_clk,
	input  logic wb_clk_i,
	input  logic wb_cyc_i,
	input  logic wb_stb_i,
	input  logic wb_we_i,
	input  logic cmd_full_i,
	input  logic wdata_full_i,
	input  logic rdata_empty_i,
	output logic wb_ack_o,
	output logic cmd_push_o,
	output logic wdata_push_o,
	output logic rdata_pop_o
);

	logic wb_req;
	logic wr_ack;
	logic rd_ack;
	logic rd_cmd_push;
	logic pending_read;

	// valid bus cycle
	assign wb_req = wb_cyc_i && wb_stb_i;

	// --------------------------------------------------
	// acknowledge
	// --------------------------------------------------
	// write acked at once when both queues have room
	assign wr_ack = wb_req && wb_we_i && !cmd_full_i && !wdata_full_i;

	// read acked together with the returned word
	assign rd_ack = wb_req && !wb_we_i && !rdata_empty_i;

	assign wb_ack_o = wr_ack || rd_ack;

	// --------------------------------------------------
	// queue strobes
	// --------------------------------------------------
	// pending flag holds off a second read command
	assign rd_cmd_push = wb_req && !wb_we_i && !cmd_full_i && !pending_read;

	// write pushes command and data on the ack edge
	assign cmd_push_o   = wr_ack || rd_cmd_push;
	assign wdata_push_o = wr_ack;
	assign rdata_pop_o  = rd_ack;

	// set on the read command edge
	// cleared by the read ack
	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			pending_read <= 1'b0;
		end else if (rd_cmd_push) begin
			pending_read <= 1'b1;
		end else if (rd_ack) begin
			pending_read <= 1'b0;
		end
	end

	// a new read finds the return queue drained
	a_one_read: assert property (
		@(posedge sdram_clk) disable iff (wb_clk_i)
		rd_cmd_push |-> rdata_empty_i
	) else $error("read command issued with returned data still queued");

endmodule

// File: logic/wb2sdrc_top.sv
// ------------------------------------------------
// bridge top: wishbone slave port on one side, sdram
// controller request and data handshakes on the other
// ------------------------------------------------
module wb2sdrc_top (
	input  logic                sdram_clk,
	input  logic                wb_clk_i,

	// wishbone slave
	input  logic                wb_cyc_i,
	input  logic                wb_stb_i,
	input  logic                wb_we_i,
	input  wb2sdrc_pkg::addr_t  wb_addr_i,
	input  wb2sdrc_pkg::data_t  wb_dat_i,
	input  wb2sdrc_pkg::sel_t   wb_sel_i,
	output wb2sdrc_pkg::data_t  wb_dat_o,
	output logic                wb_ack_o,

	// sdram controller handshakes
	output logic                sdr_req_o,
	output wb2sdrc_pkg::addr_t  sdr_req_addr_o,
	output logic                sdr_req_wr_n_o,
	input  logic                sdr_req_ack_i,
	output wb2sdrc_pkg::sel_t   sdr_wr_en_n_o,
	input  logic                sdr_wr_next_i,
	output wb2sdrc_pkg::data_t  sdr_wr_data_o,
	input  logic                sdr_rd_valid_i,
	input  wb2sdrc_pkg::data_t  sdr_rd_data_i
);

	// status from the paths
	logic cmd_full;
	logic wdata_full;
	logic rdata_empty;

	// strobes into the paths
	logic cmd_push;
	logic wdata_push;
	logic rdata_pop;

	// --------------------------------------------------
	// write path
	// --------------------------------------------------
	sdr_cmd_path u_cmd_path (
		.sdram_clk      (sdram_clk),
		.wb_clk_i       (wb_clk_i),
		.cmd_push_i     (cmd_push),
		.wdata_push_i   (wdata_push),
		.wb_we_i        (wb_we_i),
		.wb_addr_i      (wb_addr_i),
		.wb_dat_i       (wb_dat_i),
		.wb_sel_i       (wb_sel_i),
		.sdr_req_ack_i  (sdr_req_ack_i),
		.sdr_wr_next_i  (sdr_wr_next_i),
		.sdr_req_o      (sdr_req_o),
		.sdr_req_addr_o (sdr_req_addr_o),
		.sdr_req_wr_n_o (sdr_req_wr_n_o),
		.sdr_wr_en_n_o  (sdr_wr_en_n_o),
		.sdr_wr_data_o  (sdr_wr_data_o),
		.cmd_full_o     (cmd_full),
		.wdata_full_o   (wdata_full)
	);

	// read return path
	sdr_rd_return u_rd_return (
		.sdram_clk      (sdram_clk),
		.wb_clk_i       (wb_clk_i),
		.sdr_rd_valid_i (sdr_rd_valid_i),
		.sdr_rd_data_i  (sdr_rd_data_i),
		.rdata_pop_i    (rdata_pop),
		.wb_dat_o       (wb_dat_o),
		.rdata_empty_o  (rdata_empty)
	);

	// --------------------------------------------------
	// acknowledge control
	// --------------------------------------------------
	wb_ack_ctrl u_ack_ctrl (
		.sdram_clk     (sdram_clk),
		.wb_clk_i      (wb_clk_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_stb_i      (wb_stb_i),
		.wb_we_i       (wb_we_i),
		.cmd_full_i    (cmd_full),
		.wdata_full_i  (wdata_full),
		.rdata_empty_i (rdata_empty),
		.wb_ack_o      (wb_ack_o),
		.cmd_push_o    (cmd_push),
		.wdata_push_o  (wdata_push),
		.rdata_pop_o   (rdata_pop)
	);

endmodule

// File: tests/sdrc_stub.sv
// ------------------------------------------------
// behavioral sdram controller for the bridge testbench,
// random request ack delay, own memory, order and mask checks
// ------------------------------------------------
module sdrc_stub (
	input  logic               sdram_clk,
	input  logic               wb_clk_i,
	input  logic               hold_i,
	input  logic               issue_i,
	input  logic               issue_we_i,
	input  wb2sdrc_pkg::addr_t issue_addr_i,
	input  wb2sdrc_pkg::sel_t  issue_sel_i,
	input  logic               sdr_req_i,
	input  wb2sdrc_pkg::addr_t sdr_req_addr_i,
	input  logic               sdr_req_wr_n_i,
	output logic               sdr_req_ack_o,
	input  wb2sdrc_pkg::sel_t  sdr_wr_en_n_i,
	output logic               sdr_wr_next_o,
	input  wb2sdrc_pkg::data_t sdr_wr_data_i,
	output logic               sdr_rd_valid_o,
	output wb2sdrc_pkg::data_t sdr_rd_data_o,
	output int                 errors_o
);
	timeunit 1ns;
	timeprecision 1ps;

	import wb2sdrc_pkg::*;

	localparam int ent_w = 1 + $bits(sel_t) + $bits(addr_t);

	// issued commands as {we, sel, addr}, oldest first
	logic [ent_w-1:0] issued [$];
	data_t mem [addr_t];
	logic [15:0] lfsr_state = 16'd73;

	// fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// untouched words hold a pattern over the whole address
	function automatic data_t read_mem(input addr_t a);
		return mem.exists(a) ? mem[a] : (data_t'(a) ^ (data_t'(a) << 7) ^ 32'h5a5a_c3c3);
	endfunction

	always @(posedge sdram_clk) begin
		if (!wb_clk_i && issue_i) begin
			issued.push_back({issue_we_i, issue_sel_i, issue_addr_i});
		end
	end

	// --------------------------------------------------
	// one request: order check, then write or read
	// --------------------------------------------------
	task automatic serve_request();
		logic [ent_w-1:0] exp;
		logic exp_we;
		sel_t exp_sel;
		addr_t exp_addr;
		data_t word;
		if (issued.size() == 0) begin
			errors_o = errors_o + 1;
			$display("command order: request seen with no command issued");
			exp = {!sdr_req_wr_n_i, ~sdr_wr_en_n_i, sdr_req_addr_i};
		end else begin
			exp = issued.pop_front();
		end
		{exp_we, exp_sel, exp_addr} = exp;
		assert ({sdr_req_wr_n_i, sdr_req_addr_i} == {!exp_we, exp_addr}) else begin
			errors_o = errors_o + 1;
			$display("CHECK FAILED command order: expected %h actual %h",
				{!exp_we, exp_addr}, {sdr_req_wr_n_i, sdr_req_addr_i});
		end
		sdr_req_ack_o = 1'b1;
		if (!sdr_req_wr_n_i) begin
			sdr_wr_next_o = 1'b1;
			assert (sdr_wr_en_n_i == ~exp_sel) else begin
				errors_o = errors_o + 1;
				$display("CHECK FAILED write mask: expected %h actual %h",
					~exp_sel, sdr_wr_en_n_i);
			end
			// merge under the active low byte mask
			word = read_mem(sdr_req_addr_i);
			for (int b = 0; b < $bits(sel_t); b++) begin
				if (!sdr_wr_en_n_i[b]) begin
					word[8*b +: 8] = sdr_wr_data_i[8*b +: 8];
				end
			end
			mem[sdr_req_addr_i] = word;
			@(negedge sdram_clk);
			sdr_req_ack_o = 1'b0;
			sdr_wr_next_o = 1'b0;
		end else begin
			word = read_mem(sdr_req_addr_i);
			@(negedge sdram_clk);
			sdr_req_ack_o = 1'b0;
			sdr_rd_valid_o = 1'b1;
			sdr_rd_data_o = word;
			@(negedge sdram_clk);
			sdr_rd_valid_o = 1'b0;
		end
	endtask

	initial begin
		int delay;
		sdr_req_ack_o = 1'b0;
		sdr_wr_next_o = 1'b0;
		sdr_rd_valid_o = 1'b0;
		sdr_rd_data_o = '0;
		errors_o = 0;
		forever begin
			@(negedge sdram_clk);
			if (!wb_clk_i && sdr_req_i && !hold_i) begin
				// 0 to 7 cycles before the ack
				delay = take_bits(3);
				repeat (delay) @(negedge sdram_clk);
				// hold may have come up during the wait
				if (!hold_i) begin
					serve_request();
				end
			end
		end
	end

endmodule

// File: tests/wb2sdrc_tb.sv
// ------------------------------------------------
// testbench for the bridge, random writes and readback
// against a shadow memory, back-pressure and read limits
// ------------------------------------------------
`include "wb2sdrc_consts.svh"

module wb2sdrc_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import wb2sdrc_pkg::*;

	localparam int n_pool = 6;
	localparam int n_wr = 16;
	localparam int n_bp = `WB2SDRC_CMD_DEPTH + 1;
	// writes, back-pressure writes, two readback passes
	localparam int n_trans = n_wr + n_bp + 2 * n_pool;
	// sample point, a quarter period before the rising edge
	localparam int sample_delay = 10;

	logic sdram_clk = 1'b0;
	logic wb_clk_i = 1'b1;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	addr_t wb_addr;
	data_t wb_dat_w, wb_dat_r;
	sel_t wb_sel;
	logic sdr_req, sdr_req_wr_n, sdr_req_ack, sdr_wr_next, sdr_rd_valid;
	addr_t sdr_req_addr;
	sel_t sdr_wr_en_n;
	data_t sdr_wr_data, sdr_rd_data;

	logic issue, hold, started, read_out;
	int errors = 0;
	int stub_errors;
	int wr_acks, rd_acks, req_acks, in_flight;
	addr_t pool [n_pool];
	data_t shadow [addr_t];
	logic [15:0] lfsr_state = 16'd73;

	always #20 sdram_clk = ~sdram_clk;

	wb2sdrc_top dut (
		.sdram_clk(sdram_clk), .wb_clk_i(wb_clk_i),
		.wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_addr_i(wb_addr),
		.wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
		.sdr_req_o(sdr_req), .sdr_req_addr_o(sdr_req_addr), .sdr_req_wr_n_o(sdr_req_wr_n),
		.sdr_req_ack_i(sdr_req_ack), .sdr_wr_en_n_o(sdr_wr_en_n), .sdr_wr_next_i(sdr_wr_next),
		.sdr_wr_data_o(sdr_wr_data), .sdr_rd_valid_i(sdr_rd_valid), .sdr_rd_data_i(sdr_rd_data)
	);

	sdrc_stub u_stub (
		.sdram_clk(sdram_clk), .wb_clk_i(wb_clk_i), .hold_i(hold), .issue_i(issue),
		.issue_we_i(wb_we), .issue_addr_i(wb_addr), .issue_sel_i(wb_sel),
		.sdr_req_i(sdr_req), .sdr_req_addr_i(sdr_req_addr), .sdr_req_wr_n_i(sdr_req_wr_n),
		.sdr_req_ack_o(sdr_req_ack), .sdr_wr_en_n_i(sdr_wr_en_n), .sdr_wr_next_o(sdr_wr_next),
		.sdr_wr_data_i(sdr_wr_data), .sdr_rd_valid_o(sdr_rd_valid), .sdr_rd_data_o(sdr_rd_data),
		.errors_o(stub_errors)
	);

	// fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// same fill pattern as the controller memory
	function automatic data_t shadow_word(input addr_t a);
		return shadow.exists(a) ? shadow[a] : (data_t'(a) ^ (data_t'(a) << 7) ^ 32'h5a5a_c3c3);
	endfunction

	// --------------------------------------------------
	// bookkeeping and assertions
	// --------------------------------------------------
	always @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			wr_acks <= 0;
			rd_acks <= 0;
			req_acks <= 0;
			read_out <= 1'b0;
		end else begin
			if (wb_ack && wb_we) wr_acks <= wr_acks + 1;
			if (wb_ack && !wb_we) rd_acks <= rd_acks + 1;
			if (sdr_req_ack) req_acks <= req_acks + 1;
			// read taken by the controller, not yet acked on wishbone
			if (wb_ack && !wb_we) begin
				read_out <= 1'b0;
			end else if (sdr_req_ack && sdr_req && sdr_req_wr_n) begin
				read_out <= 1'b1;
			end
		end
	end

	// commands accepted on wishbone but not yet taken
	assign in_flight = wr_acks + rd_acks - req_acks;

	reset_quiet: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		!started |-> (!wb_ack && !sdr_req)) else begin
		errors = errors + 1;
		$display("reset state: ack or request active before the first strobe");
	end

	queue_bound: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		in_flight <= `WB2SDRC_CMD_DEPTH) else begin
		errors = errors + 1;
		$display("CHECK FAILED back-pressure: expected at most %0d actual %0d",
			`WB2SDRC_CMD_DEPTH, in_flight);
	end

	write_stall: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		(hold && in_flight >= `WB2SDRC_CMD_DEPTH) |-> !(wb_ack && wb_we)) else begin
		errors = errors + 1;
		$display("back-pressure: write acknowledged with the command queue full");
	end

	single_read: assert property (@(posedge sdram_clk) disable iff (wb_clk_i)
		read_out |-> !(sdr_req && sdr_req_wr_n)) else begin
		errors = errors + 1;
		$display("single read: second read command while a read is outstanding");
	end

	// --------------------------------------------------
	// wishbone master
	// --------------------------------------------------
	task automatic bus_access(input logic we, input addr_t addr, input data_t dat,
		input sel_t sel, output data_t rdata);
		logic acked;
		acked = 1'b0;
		@(negedge sdram_clk);
		started = 1'b1;
		{wb_cyc, wb_stb, wb_we, wb_addr, wb_dat_w, wb_sel} = {2'b11, we, addr, dat, sel};
		issue = 1'b1;
		while (!acked) begin
			#(sample_delay);
			acked = wb_ack;
			rdata = wb_dat_r;
			@(negedge sdram_clk);
			issue = 1'b0;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// shadow merge under the active high select
	task automatic write_word(input addr_t addr, input data_t dat, input sel_t sel);
		data_t ignored;
		data_t word;
		bus_access(1'b1, addr, dat, sel, ignored);
		word = shadow_word(addr);
		for (int b = 0; b < $bits(sel_t); b++) begin
			if (sel[b]) word[8*b +: 8] = dat[8*b +: 8];
		end
		shadow[addr] = word;
	endtask

	task automatic read_check(input addr_t addr);
		data_t exp;
		data_t got;
		exp = shadow_word(addr);
		bus_access(1'b0, addr, '0, '0, got);
		assert (got == exp) else begin
			errors = errors + 1;
			$display("CHECK FAILED readback %h: expected %h actual %h", addr, exp, got);
		end
	endtask

	task automatic release_hold();
		repeat (8) @(posedge sdram_clk);
		hold = 1'b0;
	endtask

	initial begin
		repeat (n_trans * 40) @(posedge sdram_clk);
		$display("timeout: transactions did not complete in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		data_t d;
		sel_t s;
		int idx;
		{wb_cyc, wb_stb, wb_we, wb_addr, wb_dat_w, wb_sel} = '0;
		{issue, hold, started} = 3'b000;
		repeat (5) @(posedge sdram_clk);
		@(negedge sdram_clk);
		wb_clk_i = 1'b0;
		// idle bus first, reset state watched meanwhile
		repeat (4) @(negedge sdram_clk);
		for (int i = 0; i < n_pool; i++) pool[i] = addr_t'(take_bits($bits(addr_t)));
		for (int i = 0; i < n_wr; i++) begin
			idx = take_bits(3) % n_pool;
			d = take_bits(32);
			s = sel_t'(take_bits($bits(sel_t)));
			write_word(pool[idx], d, s);
		end
		for (int i = 0; i < n_pool; i++) read_check(pool[i]);
		// controller withholds acks, last write must stall
		@(posedge sdram_clk);
		hold = 1'b1;
		for (int i = 0; i < n_bp; i++) begin
			if (i == n_bp - 1) begin
				fork
					release_hold();
				join_none
			end
			d = take_bits(32);
			s = sel_t'(take_bits($bits(sel_t)));
			write_word(pool[i % n_pool], d, s);
		end
		for (int i = 0; i < n_pool; i++) read_check(pool[i]);
		$display("errors: testbench %0d, controller stub %0d", errors, stub_errors);
		if (errors + stub_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: wb2sdrc_top.f
+incdir+logic
logic/wb2sdrc_pkg.sv
logic/sync_fifo.sv
logic/sdr_cmd_path.sv
logic/sdr_rd_return.sv
logic/wb_ack_ctrl.sv
logic/wb2sdrc_top.sv
tests/sdrc_stub.sv
tests/wb2sdrc_tb.sv

// File: Makefile
# Verilator build and run for the wishbone to sdram controller bridge

VERILATOR ?= verilator
TOP       ?= wb2sdrc_tb
FILELIST  ?= wb2sdrc_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= Everything OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard logic/*.sv logic/*.svh tests/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
